// File: Bender.yml
package:
  name: exec_core

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/rv_stage_pkg.sv
      - logic/ex_alu.sv
      - logic/regfile.sv
      - logic/lsu_mem.sv
      - logic/mem_wait_timer.sv
      - logic/exec_ctrl.sv
      - logic/exec_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/exec_core_tb.sv

// File: exec_core.f
+incdir+tests
logic/rv_isa_pkg.sv
logic/rv_stage_pkg.sv
logic/ex_alu.sv
logic/regfile.sv
logic/lsu_mem.sv
logic/mem_wait_timer.sv
logic/exec_ctrl.sv
logic/exec_core.sv
tests/exec_core_tb.sv

// File: logic/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
    input  rv_stage_pkg::issue_t             op_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      rs2_data_i,
    output logic [rv_isa_pkg::XLEN-1:0]      result_o,
    output rv_stage_pkg::mem_req_t           mem_req_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0]    opb;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    ea;

    assign opb   = op_i.use_imm ? op_i.imm : rs2_data_i;
    assign shamt = opb[SHAMT_W-1:0];
    assign ea    = rs1_data_i + op_i.imm;                    // Effective address.

    // ======================================================================
    // Result
    // ======================================================================
    always_comb begin
        case (op_i.alu_op)
            LUI:     result_o = op_i.imm;
            AUIPC:   result_o = op_i.pc + op_i.imm;
            ADD:     result_o = rs1_data_i + opb;
            SUB:     result_o = rs1_data_i - opb;
            SLL:     result_o = rs1_data_i << shamt;
            SLT:     result_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(opb)};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, rs1_data_i < opb};
            XOR:     result_o = rs1_data_i ^ opb;
            OR:      result_o = rs1_data_i | opb;
            AND:     result_o = rs1_data_i & opb;
            SRL:     result_o = rs1_data_i >> shamt;
            SRA:     result_o = $signed(rs1_data_i) >>> shamt;
            JUMP:    result_o = op_i.pc + XLEN'(4);         // Link value.
            default: result_o = '0;                          // Loads, stores, branch, nop.
        endcase
    end

    // ======================================================================
    // Memory request
    // ======================================================================
    always_comb begin
        mem_req_o.addr      = '0;
        mem_req_o.wdata     = rs2_data_i;
        mem_req_o.size      = WORD;
        mem_req_o.is_signed = 1'b0;
        mem_req_o.is_load   = 1'b0;
        mem_req_o.is_store  = 1'b0;
        case (op_i.alu_op)
            LB, LBU, SB: mem_req_o.size = BYTE;
            LH, LHU, SH: mem_req_o.size = HALF;
            default:     mem_req_o.size = WORD;
        endcase
        if (op_i.alu_op inside {LB, LH, LW, LBU, LHU}) begin
            mem_req_o.is_load   = 1'b1;
            mem_req_o.is_signed = op_i.alu_op inside {LB, LH, LW};
            mem_req_o.addr      = ea;
        end
        if (op_i.alu_op inside {SB, SH, SW}) begin
            mem_req_o.is_store = 1'b1;
            mem_req_o.addr     = ea;
        end
    end

endmodule

// File: logic/exec_core.sv
`timescale 1ns/10ps

module exec_core (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             issue_valid_i,
    input  rv_stage_pkg::issue_t             issue_i,
    output logic                             busy_o,
    output logic                             retire_valid_o,
    output rv_stage_pkg::retire_t            retire_o,
    output logic [rv_isa_pkg::XLEN-1:0]      retired_cnt_o
);
    import rv_isa_pkg::*;
    import rv_stage_pkg::*;

    issue_t                op;
    mem_req_t              mem_req;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       rf_wdata;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  rf_we;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  timer_start;
    logic                  timer_done;

    exec_ctrl u_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .alu_result_i   (alu_result),
        .mem_req_i      (mem_req),
        .load_data_i    (load_data),
        .timer_done_i   (timer_done),
        .op_o           (op),
        .mem_rd_o       (mem_rd),
        .mem_wr_o       (mem_wr),
        .timer_start_o  (timer_start),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .busy_o         (busy_o)
    );

    mem_wait_timer u_timer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .start_i       (timer_start),
        .retire_i      (retire_valid_o),
        .done_o        (timer_done),
        .retired_cnt_o (retired_cnt_o)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (op.rs1),
        .raddr2_i (op.rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    ex_alu u_alu (
        .op_i       (op),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (alu_result),
        .mem_req_o  (mem_req)
    );

    // Request stays stable while the operation is held in the controller.
    lsu_mem u_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rd_i     (mem_rd),
        .wr_i     (mem_wr),
        .req_i    (mem_req),
        .rdata_o  (load_data)
    );

endmodule

// File: logic/exec_ctrl.sv
`timescale 1ns/10ps

module exec_ctrl (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 issue_valid_i,
    input  rv_stage_pkg::issue_t                 issue_i,
    input  logic [rv_isa_pkg::XLEN-1:0]          alu_result_i,
    input  rv_stage_pkg::mem_req_t               mem_req_i,
    input  logic [rv_isa_pkg::XLEN-1:0]          load_data_i,
    input  logic                                 timer_done_i,
    output rv_stage_pkg::issue_t                 op_o,
    output logic                                 mem_rd_o,
    output logic                                 mem_wr_o,
    output logic                                 timer_start_o,
    output logic                                 rf_we_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]    rf_waddr_o,
    output logic [rv_isa_pkg::XLEN-1:0]          rf_wdata_o,
    output logic                                 retire_valid_o,
    output rv_stage_pkg::retire_t                retire_o,
    output logic                                 busy_o
);
    import rv_isa_pkg::*;
    import rv_stage_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        MEM_WAIT,
        WB
    } state_e;

    state_e          state_q;
    state_e          state_d;
    issue_t          op_q;
    logic [XLEN-1:0] result_q;
    mem_req_t        req_q;
    logic            accept;
    logic            is_mem;
    logic            wb_en;

    assign busy_o = (state_q != IDLE) || retire_valid_o;     // Covers the retire cycle.
    assign accept = issue_valid_i && !busy_o;
    assign is_mem = mem_req_i.is_load || mem_req_i.is_store;

    // ======================================================================
    // FSM
    // ======================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (accept) state_d = EXEC;
            EXEC:     state_d = is_mem ? MEM_WAIT : WB;
            MEM_WAIT: if (timer_done_i) state_d = WB;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= IDLE;
            mem_rd_o       <= 1'b0;
            mem_wr_o       <= 1'b0;
            retire_valid_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            mem_rd_o       <= (state_q == EXEC) && mem_req_i.is_load;  // One cycle.
            mem_wr_o       <= (state_q == EXEC) && mem_req_i.is_store;
            retire_valid_o <= (state_q == WB);
        end
    end

    // ======================================================================
    // Payload
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= issue_i;
        end
        if (state_q == EXEC) begin
            result_q <= alu_result_i;
            req_q    <= mem_req_i;
        end
        if (state_q == WB) begin
            retire_o.alu_op   <= op_q.alu_op;
            retire_o.rd       <= op_q.rd;
            retire_o.rd_en    <= wb_en;
            retire_o.rd_data  <= rf_wdata_o;
            retire_o.mem_addr <= req_q.addr;
        end
    end

    assign op_o          = op_q;
    assign timer_start_o = (state_q == EXEC) && is_mem;
    assign wb_en         = op_q.rd_en && op_writes_rd(op_q.alu_op);
    assign rf_we_o       = (state_q == WB) && wb_en;
    assign rf_waddr_o    = op_q.rd;
    assign rf_wdata_o    = req_q.is_load ? load_data_i : result_q;

endmodule

// File: logic/lsu_mem.sv
`timescale 1ns/10ps

module lsu_mem (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             rd_i,
    input  logic                             wr_i,
    input  rv_stage_pkg::mem_req_t           req_i,
    output logic [rv_isa_pkg::XLEN-1:0]      rdata_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0]       mem_q [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;
    logic [1:0]            byte_off;
    logic [BYTE_LANES-1:0] byte_en;
    logic [XLEN-1:0]       wdata_lanes;
    logic [XLEN-1:0]       word_rd;
    logic [7:0]            byte_rd;
    logic [15:0]           half_rd;
    logic [XLEN-1:0]       load_ext;

    assign word_idx = req_i.addr[2 +: DMEM_IDX_W];           // Wraps modulo depth.
    assign byte_off = req_i.addr[1:0];
    assign word_rd  = mem_q[word_idx];

    // ======================================================================
    // Store lanes
    // ======================================================================
    always_comb begin
        case (req_i.size)
            BYTE: begin
                byte_en     = BYTE_LANES'(1) << byte_off;
                wdata_lanes = {BYTE_LANES{req_i.wdata[7:0]}};
            end
            HALF: begin
                byte_en     = byte_off[1] ? {2'b11, 2'b00} : {2'b00, 2'b11};
                wdata_lanes = {2{req_i.wdata[15:0]}};
            end
            default: begin
                byte_en     = '1;
                wdata_lanes = req_i.wdata;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (byte_en[b]) begin
                    mem_q[word_idx][8*b +: 8] <= wdata_lanes[8*b +: 8];
                end
            end
        end
    end

    // ======================================================================
    // Load extract and extend
    // ======================================================================
    assign byte_rd = word_rd[8*byte_off +: 8];
    assign half_rd = byte_off[1] ? word_rd[31:16] : word_rd[15:0];

    always_comb begin
        case (req_i.size)
            BYTE:    load_ext = {{(XLEN-8){req_i.is_signed & byte_rd[7]}}, byte_rd};
            HALF:    load_ext = {{(XLEN-16){req_i.is_signed & half_rd[15]}}, half_rd};
            default: load_ext = word_rd;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (rd_i) begin
            rdata_o <= load_ext;
        end
    end

endmodule

// File: logic/mem_wait_timer.sv
`timescale 1ns/10ps

module mem_wait_timer (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             start_i,
    input  logic                             retire_i,
    output logic                             done_o,
    output logic [rv_isa_pkg::XLEN-1:0]      retired_cnt_o
);
    import rv_stage_pkg::*;

    logic [MEM_WAIT_CNT_W-1:0] wait_cnt_q;
    logic                      active_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cnt_q    <= '0;
            active_q      <= 1'b0;
            retired_cnt_o <= '0;
        end else begin
            if (start_i) begin
                wait_cnt_q <= MEM_WAIT_CNT_W'(MEM_WAIT_CYCLES - 1);
                active_q   <= 1'b1;
            end else if (active_q) begin
                if (wait_cnt_q == '0) begin
                    active_q <= 1'b0;
                end else begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                end
            end
            if (retire_i) begin
                retired_cnt_o <= retired_cnt_o + 1'b1;
            end
        end
    end

    assign done_o = active_q && (wait_cnt_q == '0);          // MEM_WAIT_CYCLES after start.

endmodule

// File: logic/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]    raddr1_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]    raddr2_i,
    output logic [rv_isa_pkg::XLEN-1:0]          rdata1_o,
    output logic [rv_isa_pkg::XLEN-1:0]          rdata2_o,
    input  logic                                 we_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]    waddr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]          wdata_i
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin      // x0 stays zero.
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // ======================================================================
    // Widths and sizes
    // ======================================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int SHAMT_W    = $clog2(XLEN);                 // Low bits of operand b.
    localparam int BYTE_LANES = XLEN / 8;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // ======================================================================
    // Operation and access encodings
    // ======================================================================
    // Immediate forms share a code with the register form.
    typedef enum logic [4:0] {
        NOP,
        LUI, AUIPC,
        ADD, SUB, SLL, SLT, SLTU, XOR, OR, AND, SRL, SRA,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        JUMP,
        BRANCH
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } mem_size_e;

    // Operations that never touch rd, whatever the decoder asks.
    function automatic logic op_writes_rd(alu_op_e op);
        return !(op inside {NOP, BRANCH, SB, SH, SW});
    endfunction

endpackage

// File: logic/rv_stage_pkg.sv
package rv_stage_pkg;

    localparam int MEM_WAIT_CYCLES = 3;
    localparam int MEM_WAIT_CNT_W  = $clog2(MEM_WAIT_CYCLES + 1);

    // ======================================================================
    // Stage payloads
    // ======================================================================
    typedef struct packed {
        rv_isa_pkg::alu_op_e                   alu_op;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs1;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs2;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]     rd;
        logic                                  rd_en;
        logic                                  use_imm;
        logic [rv_isa_pkg::XLEN-1:0]           imm;
        logic [rv_isa_pkg::XLEN-1:0]           pc;
    } issue_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]           addr;      // Unaligned, rs1 + imm.
        logic [rv_isa_pkg::XLEN-1:0]           wdata;
        rv_isa_pkg::mem_size_e                 size;
        logic                                  is_signed;
        logic                                  is_load;
        logic                                  is_store;
    } mem_req_t;

    typedef struct packed {
        rv_isa_pkg::alu_op_e                   alu_op;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]     rd;
        logic                                  rd_en;
        logic [rv_isa_pkg::XLEN-1:0]           rd_data;
        logic [rv_isa_pkg::XLEN-1:0]           mem_addr;
    } retire_t;

endpackage

// File: tests/exec_core_ref.svh
`ifndef EXEC_CORE_REF_SVH
`define EXEC_CORE_REF_SVH

// Shadow architectural state, updated as each operation is issued.
logic [XLEN-1:0] shadow_regs [NUM_REGS];
logic [XLEN-1:0] shadow_mem  [DMEM_WORDS];

function automatic void shadow_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        shadow_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        shadow_mem[i] = '0;
    end
endfunction

// Keep the low bits and fill the rest with the sign or zero.
function automatic logic [XLEN-1:0] extend_value(input logic [XLEN-1:0] raw, input int bits,
                                                 input logic sgn);
    logic [XLEN-1:0] mask;
    logic            fill;
    mask = (bits >= XLEN) ? '1 : ((XLEN'(1) << bits) - 1);
    fill = sgn && raw[bits-1];
    return (raw & mask) | (fill ? ~mask : '0);
endfunction

function automatic retire_t ref_execute(input issue_t op);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] ea;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] word;
    int              idx;
    int              lane;
    logic            writes;
    retire_t         r;
    a    = shadow_regs[op.rs1];
    b    = shadow_regs[op.rs2];
    opb  = op.use_imm ? op.imm : b;
    ea   = a + op.imm;
    idx  = int'((ea / 4) % DMEM_WORDS);                       // Word index wraps.
    lane = int'(ea % 4);
    word = shadow_mem[idx];
    res  = '0;
    case (op.alu_op)
        LUI:    res = op.imm;
        AUIPC:  res = op.pc + op.imm;
        ADD:    res = a + opb;
        SUB:    res = a - opb;
        SLL:    res = a << opb[4:0];
        SLT:    res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
        SLTU:   res = (a < opb) ? 32'd1 : 32'd0;
        XOR:    res = a ^ opb;
        OR:     res = a | opb;
        AND:    res = a & opb;
        SRL:    res = a >> opb[4:0];
        SRA:    res = $signed(a) >>> opb[4:0];
        JUMP:   res = op.pc + 32'd4;
        LB:     res = extend_value(word >> (8 * lane), 8, 1'b1);
        LBU:    res = extend_value(word >> (8 * lane), 8, 1'b0);
        LH:     res = extend_value(word >> (16 * (lane / 2)), 16, 1'b1);  // Aligned down.
        LHU:    res = extend_value(word >> (16 * (lane / 2)), 16, 1'b0);
        LW:     res = word;
        SB: begin
            word[8*lane +: 8] = b[7:0];
            shadow_mem[idx]   = word;
        end
        SH: begin
            word[16*(lane/2) +: 16] = b[15:0];
            shadow_mem[idx]         = word;
        end
        SW:     shadow_mem[idx] = b;
        default: res = '0;
    endcase
    writes = op.rd_en && !(op.alu_op inside {NOP, BRANCH, SB, SH, SW});
    if (writes && (op.rd != '0)) begin
        shadow_regs[op.rd] = res;
    end
    r.alu_op   = op.alu_op;
    r.rd       = op.rd;
    r.rd_en    = writes;
    r.rd_data  = res;
    r.mem_addr = (op.alu_op inside {LB, LH, LW, LBU, LHU, SB, SH, SW}) ? ea : '0;
    return r;
endfunction

`endif

// File: tests/exec_core_tb.sv
`timescale 1ns/10ps

module exec_core_tb;
    import rv_isa_pkg::*;
    import rv_stage_pkg::*;

    localparam int DRIVE_DLY   = 2;
    localparam int TIMEOUT_CYC = 40;

    bit              clk;
    logic            arst_n;
    logic            issue_valid;
    issue_t          issue_pkt;
    logic            busy;
    logic            retire_valid;
    retire_t         retire_pkt;
    logic [XLEN-1:0] retired_cnt;

    integer  seed;
    int      cycle_cnt;
    int      retires_seen;
    bit      issue_started;
    bit      retire_prev;
    bit      aborted;
    int      err_value;
    int      err_timing;
    int      err_protocol;
    int      err_timeout;
    retire_t exp_q [$];
    int      exp_cyc_q [$];
    retire_t exp_r;
    int      exp_cyc;

    alu_op_e alu_list [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, OR, AND, SRL, SRA};
    alu_op_e load_list [5] = '{LB, LH, LW, LBU, LHU};

    `include "exec_core_ref.svh"

    exec_core u_dut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .issue_valid_i  (issue_valid),
        .issue_i        (issue_pkt),
        .busy_o         (busy),
        .retire_valid_o (retire_valid),
        .retire_o       (retire_pkt),
        .retired_cnt_o  (retired_cnt)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] imm12(input logic [XLEN-1:0] r);
        return {{(XLEN-12){r[11]}}, r[11:0]};
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic int retire_latency(input alu_op_e op);
        return (op inside {LB, LH, LW, LBU, LHU, SB, SH, SW}) ? 2 + MEM_WAIT_CYCLES : 2;
    endfunction

    function automatic issue_t make_op(input alu_op_e alu_op, input int rd, input int rs1,
                                       input int rs2, input logic use_imm,
                                       input logic [XLEN-1:0] imm);
        issue_t op;
        op.alu_op  = alu_op;
        op.rd      = REG_ADDR_W'(rd);
        op.rs1     = REG_ADDR_W'(rs1);
        op.rs2     = REG_ADDR_W'(rs2);
        op.rd_en   = 1'b1;
        op.use_imm = use_imm;
        op.imm     = imm;
        op.pc      = '0;
        return op;
    endfunction

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
            err_value++;
        end
    endtask

    task automatic next_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic flag_timeout(input string what);
        $display("Timeout while waiting for %s at cycle %0d", what, cycle_cnt);
        err_timeout++;
        aborted = 1'b1;
    endtask

    // ======================================================================
    // Comparison process
    // ======================================================================
    always @(negedge clk) begin
        if (!issue_started) begin
            compare_word("busy_o", busy, 1'b0);                // Idle before the first issue.
        end
        if (!arst_n) begin
            compare_word("retire_valid_o", retire_valid, 1'b0);
            compare_word("retired_cnt_o", retired_cnt, '0);
        end else begin
            compare_word("retired_cnt_o", retired_cnt, XLEN'(retires_seen));
            if (retire_prev) begin
                compare_word("busy_o", busy, 1'b0);            // Free the cycle after a retire.
            end
            retire_prev = (retire_valid === 1'b1);
            if (retire_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Retire strobe at cycle %0d with no operation outstanding",
                             cycle_cnt);
                    err_protocol++;
                end else begin
                    exp_r   = exp_q.pop_front();
                    exp_cyc = exp_cyc_q.pop_front();
                    if (cycle_cnt != exp_cyc) begin
                        $display("Retire arrived at cycle %0d instead of cycle %0d",
                                 cycle_cnt, exp_cyc);
                        err_timing++;
                    end
                    compare_word("retire_o.alu_op", retire_pkt.alu_op, exp_r.alu_op);
                    compare_word("retire_o.rd", retire_pkt.rd, exp_r.rd);
                    compare_word("retire_o.rd_en", retire_pkt.rd_en, exp_r.rd_en);
                    compare_word("retire_o.rd_data", retire_pkt.rd_data, exp_r.rd_data);
                    compare_word("retire_o.mem_addr", retire_pkt.mem_addr, exp_r.mem_addr);
                end
                retires_seen++;
            end
        end
    end

    // ======================================================================
    // Stimulus tasks
    // ======================================================================
    task automatic issue_op(input issue_t op);
        int waited;
        if (aborted) begin
            return;
        end
        waited = 0;
        while (busy !== 1'b0) begin
            if (waited >= TIMEOUT_CYC) begin
                flag_timeout("busy_o to drop before an issue");
                return;
            end
            next_slot();
            waited++;
        end
        issue_started = 1'b1;
        issue_valid   = 1'b1;
        issue_pkt     = op;
        exp_q.push_back(ref_execute(op));
        exp_cyc_q.push_back(cycle_cnt + 1 + retire_latency(op.alu_op));  // Next edge accepts.
        next_slot();
        issue_valid = 1'b0;
        issue_pkt   = '0;
    endtask

    // Strobe that the DUT must ignore.
    task automatic pulse_while_busy(input issue_t op);
        if (aborted) begin
            return;
        end
        compare_word("busy_o", busy, 1'b1);
        issue_valid = 1'b1;
        issue_pkt   = op;
        next_slot();
        issue_valid = 1'b0;
        issue_pkt   = '0;
    endtask

    task automatic wait_retire_strobe();
        int waited;
        waited = 0;
        while (!aborted && (retire_valid !== 1'b1)) begin
            if (waited >= TIMEOUT_CYC) begin
                flag_timeout("retire_valid_o");
                return;
            end
            next_slot();
            waited++;
        end
    endtask

    task automatic load_reg(input int rd, input logic [XLEN-1:0] v);
        logic [XLEN-1:0] hi;
        hi = (v + 32'h800) & 32'hffff_f000;                  // Upper part after low sign.
        issue_op(make_op(LUI, rd, 0, 0, 1'b1, hi));
        issue_op(make_op(ADD, rd, rd, 0, 1'b1, imm12(v)));
    endtask

    task automatic alu_random_sweep(input int count);
        issue_t op;
        for (int k = 0; k < 20; k++) begin                   // Every op in both forms.
            op = make_op(alu_list[k / 2], 1 + rand_word() % 31, rand_word() % 32,
                         rand_word() % 32, 1'(k % 2), imm12(rand_word()));
            issue_op(op);
        end
        for (int k = 0; k < count; k++) begin
            op = make_op(alu_list[rand_word() % 10], 1 + rand_word() % 31, rand_word() % 32,
                         rand_word() % 32, 1'(rand_word() % 2), imm12(rand_word()));
            op.rd_en = (rand_word() % 8) != 0;
            issue_op(op);
        end
    endtask

    task automatic upper_jump_branch();
        issue_t op;
        issue_op(make_op(LUI, 10, 0, 0, 1'b1, rand_word() & 32'hffff_f000));
        op    = make_op(AUIPC, 11, 0, 0, 1'b1, rand_word() & 32'hffff_f000);
        op.pc = rand_word() & ~32'h3;
        issue_op(op);
        op    = make_op(JUMP, 12, 3, 0, 1'b1, imm12(rand_word()));
        op.pc = rand_word() & ~32'h3;
        issue_op(op);
        op    = make_op(BRANCH, 13, 10, 11, 1'b0, imm12(rand_word()));
        op.pc = rand_word() & ~32'h3;
        issue_op(op);
        issue_op(make_op(NOP, 14, 0, 0, 1'b0, '0));
        issue_op(make_op(ADD, 0, 13, 0, 1'b0, '0));           // Read back x13.
    endtask

    task automatic store_load_sweep();
        logic [XLEN-1:0] addr;
        load_reg(20, 32'h0000_0100);
        load_reg(23, 32'h0000_0140);
        for (int w = 0; w < 16; w++) begin
            addr = 32'h100 + 4 * w;
            load_reg(21, fill_word(addr));
            issue_op(make_op(SW, 0, 20, 21, 1'b1, 4 * w));
        end
        for (int k = 0; k < 4; k++) begin                    // Offset k inside the word.
            load_reg(22, rand_word());
            issue_op(make_op(SB, 0, 20, 22, 1'b1, 5 * k));
            issue_op(make_op(SH, 0, 20, 22, 1'b1, 32'h10 + 5 * k));
            issue_op(make_op(SW, 0, 20, 22, 1'b1, 32'h20 + 5 * k));
        end
        issue_op(make_op(SB, 0, 23, 22, 1'b1, imm12(32'hffd)));
        for (int a = 0; a < 48; a++) begin
            for (int j = 0; j < 5; j++) begin
                issue_op(make_op(load_list[j], 24 + j, 20, 0, 1'b1, a));
            end
        end
        issue_op(make_op(LW, 26, 20, 0, 1'b1, 32'h400));      // Wraps onto the base word.
        issue_op(make_op(LBU, 27, 20, 0, 1'b1, 32'h403));
        issue_op(make_op(LH, 28, 23, 0, 1'b1, imm12(32'hffa)));
    endtask

    task automatic x0_and_busy_drop();
        issue_t drop;
        drop = make_op(ADD, 9, 9, 0, 1'b1, imm12(32'h77));
        issue_op(make_op(ADD, 0, 5, 0, 1'b1, imm12(32'd123)));
        issue_op(make_op(LUI, 0, 0, 0, 1'b1, 32'hfeed_0000));
        issue_op(make_op(OR, 0, 0, 0, 1'b0, '0));             // x0 still zero.
        issue_op(make_op(XOR, 7, 7, 8, 1'b0, '0));
        pulse_while_busy(drop);
        issue_op(make_op(LW, 25, 20, 0, 1'b1, 32'h8));
        next_slot();
        next_slot();
        pulse_while_busy(drop);                              // During the memory wait.
        wait_retire_strobe();
        pulse_while_busy(drop);                              // In the retire cycle.
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            issue_op(make_op(ADD, 0, i, 0, 1'b0, '0));
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!aborted && (exp_q.size() != 0)) begin
            if (waited >= TIMEOUT_CYC) begin
                flag_timeout("the outstanding retires");
                return;
            end
            next_slot();
            waited++;
        end
        for (int i = 0; i < 8; i++) begin                    // Watch for stray retires.
            next_slot();
        end
    endtask

    task automatic finish_run();
        $display("Error counts: value %0d, timing %0d, protocol %0d, timeout %0d",
                 err_value, err_timing, err_protocol, err_timeout);
        if ((err_value + err_timing + err_protocol + err_timeout) == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        seed          = 32'hdf7b_2cc5;
        clk           = 1'b0;
        arst_n        = 1'b0;
        issue_valid   = 1'b0;
        issue_pkt     = '0;
        cycle_cnt     = 0;
        retires_seen  = 0;
        issue_started = 1'b0;
        retire_prev   = 1'b0;
        aborted       = 1'b0;
        err_value     = 0;
        err_timing    = 0;
        err_protocol  = 0;
        err_timeout   = 0;
        shadow_reset();
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        for (int i = 0; i < 3; i++) begin
            next_slot();
        end
        for (int r = 1; r < NUM_REGS; r++) begin
            load_reg(r, rand_word());
        end
        alu_random_sweep(80);
        upper_jump_branch();
        store_load_sweep();
        x0_and_busy_drop();
        read_all_regs();
        wait_drain();
        finish_run();
    end

endmodule
